/* hdl/periph_consts.svh */
/* peripheral block constants
   timebase, uart bit rate, fifo depth and register map */
`ifndef PERIPH_CONSTS_SVH
`define PERIPH_CONSTS_SVH

// ------------------------------
// timing

// clock cycles per microsecond
`define CLK_MHZ 4

// clock cycles per uart bit
`define UART_CLKDIV 8

// transmit fifo entries
`define TX_FIFO_DEPTH 4

// ------------------------------
// address map

// 1 selects uart, 0 selects timer
`define REGION_BIT 14

// uart region
`define UART_TXDATA_OFS 'h00
`define UART_STATUS_OFS 'h04

// timer region, 0x04 left unmapped
`define TMR_CTRL_OFS     'h00
`define TMR_MTIME_LO_OFS 'h08
`define TMR_MTIME_HI_OFS 'h0c
`define TMR_CMP_LO_OFS   'h10
`define TMR_CMP_HI_OFS   'h14

`endif

/* hdl/apb_bus_pkg.sv */
/* apb slave bus types
   address and data word of the peripheral port */
package apb_bus_pkg;

	// byte address inside the peripheral block
	typedef logic [15:0] paddr_t;

	// read and write data word
	typedef logic [31:0] pdata_t;

endpackage

/* hdl/periph_pkg.sv */
/* peripheral types
   uart character, fifo occupancy, timer count and register/state enums */
package periph_pkg;

	`include "periph_consts.svh"

	// one uart character
	typedef logic [7:0] tx_byte_t;

	// occupancy, must hold the depth itself
	typedef logic [$clog2(`TX_FIFO_DEPTH + 1)-1:0] fifo_level_t;

	// mtime and mtimecmp
	typedef logic [63:0] mtime_t;

	// timer registers as seen on the timer bus
	typedef enum logic [2:0] {
		tmr_ctrl,
		tmr_mtime_lo,
		tmr_mtime_hi,
		tmr_cmp_lo,
		tmr_cmp_hi
	} tmr_reg_e;

	// serializer frame phases
	typedef enum logic [1:0] {
		st_idle,
		st_start,
		st_data,
		st_stop
	} tx_state_e;

endpackage

/* hdl/periph_if.sv */
/* internal buses of the peripheral block
   transmit push bus and timer register bus */
`timescale 1ns/1ps

// ------------------------------
// register block to transmit fifo

interface tx_push_if;
	import periph_pkg::*;

	// one cycle strobe, only while not full
	logic        push;
	tx_byte_t    data;
	logic        full;
	fifo_level_t level;

	modport producer (
		output push,
		output data,
		input  full,
		input  level
	);

	modport fifo (
		input  push,
		input  data,
		output full,
		output level
	);
endinterface

// ------------------------------
// register block to machine timer

interface tmr_bus_if;
	import apb_bus_pkg::*;
	import periph_pkg::*;

	// write lands at the edge closing the strobe
	logic     wr;
	tmr_reg_e sel;
	pdata_t   wdata;
	// combinational, follows sel
	pdata_t   rdata;

	modport master (
		output wr,
		output sel,
		output wdata,
		input  rdata
	);

	modport timer (
		input  wr,
		input  sel,
		input  wdata,
		output rdata
	);
endinterface

/* hdl/apb_periph_regs.sv */
/* apb slave register block
   splits the port into uart and timer regions, pushes tx bytes, forwards timer access */
`timescale 1ns/1ps

`include "periph_consts.svh"

module apb_periph_regs (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_psel,
	input  logic                i_penable,
	input  logic                i_pwrite,
	input  apb_bus_pkg::paddr_t i_paddr,
	input  apb_bus_pkg::pdata_t i_pwdata,
	output apb_bus_pkg::pdata_t o_prdata,
	output logic                o_pready,
	output logic                o_pslverr,
	input  logic                i_tx_busy,
	tx_push_if.producer         txp,
	tmr_bus_if.master           tmr
);
	import apb_bus_pkg::*;
	import periph_pkg::*;

	logic                   access;
	logic                   upper_zero;
	logic                   uart_region;
	logic [`REGION_BIT-1:0] ofs;
	logic                   tmr_hit;
	pdata_t                 status_word;

	// second apb phase, no wait states
	assign access      = i_psel && i_penable;
	assign o_pready    = 1'b1;
	// bits above the region select must be zero
	assign upper_zero  = ~|i_paddr[$bits(paddr_t)-1:`REGION_BIT+1];
	assign uart_region = i_paddr[`REGION_BIT];
	assign ofs         = i_paddr[`REGION_BIT-1:0];

	// status: busy, level, full from lsb up
	assign status_word = pdata_t'({i_tx_busy, txp.level, txp.full});

	assign txp.data  = i_pwdata[7:0];
	assign tmr.wdata = i_pwdata;

	// timer offset to register select
	always_comb begin
		tmr_hit = 1'b1;
		tmr.sel = tmr_ctrl;
		case (ofs)
			`TMR_CTRL_OFS:     tmr.sel = tmr_ctrl;
			`TMR_MTIME_LO_OFS: tmr.sel = tmr_mtime_lo;
			`TMR_MTIME_HI_OFS: tmr.sel = tmr_mtime_hi;
			`TMR_CMP_LO_OFS:   tmr.sel = tmr_cmp_lo;
			`TMR_CMP_HI_OFS:   tmr.sel = tmr_cmp_hi;
			default:           tmr_hit = 1'b0;
		endcase
	end

	// ------------------------------
	// access cycle decode

	always_comb begin
		o_prdata  = '0;
		o_pslverr = 1'b0;
		txp.push  = 1'b0;
		tmr.wr    = 1'b0;
		if (access) begin
			if (!upper_zero) begin
				o_pslverr = 1'b1;
			end else if (uart_region) begin
				case (ofs)
					`UART_TXDATA_OFS: begin
						// byte dropped when the fifo is full
						if (i_pwrite) begin
							if (txp.full)
								o_pslverr = 1'b1;
							else
								txp.push = 1'b1;
						end
					end
					`UART_STATUS_OFS: begin
						// read only
						if (i_pwrite)
							o_pslverr = 1'b1;
						else
							o_prdata = status_word;
					end
					default: o_pslverr = 1'b1;
				endcase
			end else if (!tmr_hit) begin
				o_pslverr = 1'b1;
			end else if (i_pwrite) begin
				tmr.wr = 1'b1;
			end else begin
				o_prdata = tmr.rdata;
			end
		end
	end

	// full comes back from the fifo in the same cycle
	a_no_push_when_full: assert property (
		@(posedge clk) disable iff (!rst_n) !(txp.push && txp.full)
	);

endmodule

/* hdl/mtimer.sv */
/* machine timer
   microsecond timebase, 64-bit mtime and mtimecmp, level interrupt */
`timescale 1ns/1ps

`include "periph_consts.svh"

module mtimer (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     i_dbg_halt,
	tmr_bus_if.timer tmr,
	output logic     o_timer_irq
);
	import periph_pkg::*;

	logic [$clog2(`CLK_MHZ)-1:0] tick_ctr;
	logic                        tick;
	logic                        enable;
	mtime_t                      mtime;
	mtime_t                      mtimecmp;

	// tick once per microsecond, free running
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			tick_ctr <= '0;
		else if (tick)
			tick_ctr <= $bits(tick_ctr)'(`CLK_MHZ - 1);
		else
			tick_ctr <= tick_ctr - 1'b1;
	end

	assign tick = (tick_ctr == '0);

	// ------------------------------
	// registers

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			enable   <= 1'b0;
			mtime    <= '0;
			mtimecmp <= '1;
		end else begin
			if (tmr.wr && tmr.sel == tmr_ctrl)
				enable <= tmr.wdata[0];
			if (tmr.wr && tmr.sel == tmr_cmp_lo)
				mtimecmp[31:0] <= tmr.wdata;
			if (tmr.wr && tmr.sel == tmr_cmp_hi)
				mtimecmp[63:32] <= tmr.wdata;
			// a write to either half wins over the count
			if (tmr.wr && tmr.sel == tmr_mtime_lo)
				mtime[31:0] <= tmr.wdata;
			else if (tmr.wr && tmr.sel == tmr_mtime_hi)
				mtime[63:32] <= tmr.wdata;
			else if (tick && enable && !i_dbg_halt)
				mtime <= mtime + 64'd1;
		end
	end

	// compare registered, one cycle late
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			o_timer_irq <= 1'b0;
		else
			o_timer_irq <= (mtime >= mtimecmp);
	end

	always_comb begin
		case (tmr.sel)
			tmr_ctrl:     tmr.rdata = {31'd0, enable};
			tmr_mtime_lo: tmr.rdata = mtime[31:0];
			tmr_mtime_hi: tmr.rdata = mtime[63:32];
			tmr_cmp_lo:   tmr.rdata = mtimecmp[31:0];
			tmr_cmp_hi:   tmr.rdata = mtimecmp[63:32];
			default:      tmr.rdata = '0;
		endcase
	end

	a_mtime_stable: assert property (
		@(posedge clk) disable iff (!rst_n) !(tick || tmr.wr) |=> $stable(mtime)
	);

endmodule

/* hdl/tx_fifo.sv */
/* transmit byte fifo
   circular buffer with read/write pointers and level count */
`timescale 1ns/1ps

`include "periph_consts.svh"

module tx_fifo (
	input  logic                clk,
	input  logic                rst_n,
	tx_push_if.fifo             txp,
	output logic                o_valid,
	output periph_pkg::tx_byte_t o_data,
	input  logic                i_pop
);
	import periph_pkg::*;

	tx_byte_t                          mem [`TX_FIFO_DEPTH];
	logic [$clog2(`TX_FIFO_DEPTH)-1:0] wr_ptr;
	logic [$clog2(`TX_FIFO_DEPTH)-1:0] rd_ptr;
	fifo_level_t                       level;

	// storage, written at the push edge
	always_ff @(posedge clk) begin
		if (txp.push)
			mem[wr_ptr] <= txp.data;
	end

	// ------------------------------
	// pointers and level

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (txp.push)
				wr_ptr <= (wr_ptr == `TX_FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (i_pop)
				rd_ptr <= (rd_ptr == `TX_FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			// push and pop together leave the level
			if (txp.push && !i_pop)
				level <= level + 1'b1;
			else if (i_pop && !txp.push)
				level <= level - 1'b1;
		end
	end

	assign txp.level = level;
	assign txp.full  = (level == `TX_FIFO_DEPTH);
	assign o_valid   = (level != '0);
	// head byte
	assign o_data    = mem[rd_ptr];

	a_push_not_full: assert property (
		@(posedge clk) disable iff (!rst_n) txp.push |-> !txp.full
	);

	a_pop_not_empty: assert property (
		@(posedge clk) disable iff (!rst_n) i_pop |-> o_valid
	);

endmodule

/* hdl/uart_tx_serial.sv */
/* uart transmit serializer
   pops fifo bytes and shifts them out as 8n1 frames */
`timescale 1ns/1ps

`include "periph_consts.svh"

module uart_tx_serial (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_valid,
	input  periph_pkg::tx_byte_t i_data,
	output logic                 o_pop,
	output logic                 o_busy,
	output logic                 o_uart_tx
);
	import periph_pkg::*;

	tx_state_e                       state;
	logic [$clog2(`UART_CLKDIV)-1:0] div_ctr;
	logic                            bit_end;
	logic [2:0]                      bit_idx;
	tx_byte_t                        shreg;
	logic                            line;

	// last cycle of the current bit
	assign bit_end = (div_ctr == $bits(div_ctr)'(`UART_CLKDIV - 1));

	// take a byte from idle or straight after a stop bit
	assign o_pop     = i_valid && ((state == st_idle) || (state == st_stop && bit_end));
	assign o_busy    = (state != st_idle);
	assign o_uart_tx = line;

	// ------------------------------
	// frame sequencing

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= st_idle;
			div_ctr <= '0;
			bit_idx <= '0;
			line    <= 1'b1;
		end else begin
			if (state == st_idle || bit_end)
				div_ctr <= '0;
			else
				div_ctr <= div_ctr + 1'b1;
			if (o_pop) begin
				// start bit begins with the pop
				state <= st_start;
				line  <= 1'b0;
			end else begin
				case (state)
					st_idle: state <= st_idle;
					st_start: begin
						if (bit_end) begin
							state   <= st_data;
							bit_idx <= '0;
							line    <= shreg[0];
						end
					end
					st_data: begin
						if (bit_end) begin
							if (bit_idx == 3'd7) begin
								state <= st_stop;
								line  <= 1'b1;
							end else begin
								bit_idx <= bit_idx + 1'b1;
								line    <= shreg[1];
							end
						end
					end
					st_stop: begin
						if (bit_end)
							state <= st_idle;
					end
					default: state <= st_idle;
				endcase
			end
		end
	end

	// lsb first
	always_ff @(posedge clk) begin
		if (o_pop)
			shreg <= i_data;
		else if (state == st_data && bit_end)
			shreg <= shreg >> 1;
	end

	a_idle_line_high: assert property (
		@(posedge clk) disable iff (!rst_n) (state == st_idle) |-> o_uart_tx
	);

endmodule

/* hdl/periph_top.sv */
/* apb peripheral block top
   register block, machine timer, tx fifo and uart serializer */
`timescale 1ns/1ps

module periph_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_psel,
	input  logic                i_penable,
	input  logic                i_pwrite,
	input  apb_bus_pkg::paddr_t i_paddr,
	input  apb_bus_pkg::pdata_t i_pwdata,
	input  logic                i_dbg_halt,
	output apb_bus_pkg::pdata_t o_prdata,
	output logic                o_pready,
	output logic                o_pslverr,
	output logic                o_uart_tx,
	output logic                o_timer_irq
);
	import periph_pkg::*;

	// fifo head to serializer
	logic     fifo_valid;
	tx_byte_t fifo_data;
	logic     fifo_pop;
	logic     tx_busy;

	tx_push_if txp ();
	tmr_bus_if tmr ();

	// ------------------------------
	// producer and timer sibling

	apb_periph_regs u_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.i_tx_busy (tx_busy),
		.txp       (txp.producer),
		.tmr       (tmr.master)
	);

	mtimer u_mtimer (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_dbg_halt  (i_dbg_halt),
		.tmr         (tmr.timer),
		.o_timer_irq (o_timer_irq)
	);

	// ------------------------------
	// buffer and consumer

	tx_fifo u_tx_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.txp     (txp.fifo),
		.o_valid (fifo_valid),
		.o_data  (fifo_data),
		.i_pop   (fifo_pop)
	);

	uart_tx_serial u_uart_tx (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_valid   (fifo_valid),
		.i_data    (fifo_data),
		.o_pop     (fifo_pop),
		.o_busy    (tx_busy),
		.o_uart_tx (o_uart_tx)
	);

endmodule

/* sim/tb_periph_top.sv */
/* testbench for the apb peripheral block
   register cases from file, uart framing, fifo back-pressure, timer irq and debug halt */
`timescale 1ns/1ps

`include "periph_consts.svh"

module tb_periph_top;
	import apb_bus_pkg::*;

	localparam paddr_t uart_base = paddr_t'(1) << `REGION_BIT;
	// one frame is ten bits
	localparam int frame_cycles = 10 * `UART_CLKDIV;

	logic        clk;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	paddr_t      paddr;
	pdata_t      pwdata;
	logic        dbg_halt;
	pdata_t      prdata;
	logic        pready;
	logic        pslverr;
	logic        uart_tx;
	logic        timer_irq;

	int          checks;
	int          value_errs;
	int          other_errs;
	logic [31:0] lfsr;
	logic [7:0]  rx_q[$];
	logic [7:0]  exp_q[$];

	periph_top UUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_psel      (psel),
		.i_penable   (penable),
		.i_pwrite    (pwrite),
		.i_paddr     (paddr),
		.i_pwdata    (pwdata),
		.i_dbg_halt  (dbg_halt),
		.o_prdata    (prdata),
		.o_pready    (pready),
		.o_pslverr   (pslverr),
		.o_uart_tx   (uart_tx),
		.o_timer_irq (timer_irq)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// ------------------------------
	// helpers

	// galois form shifting right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	// one lfsr step per bit taken
	task automatic rand_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input [8*32-1:0] name, input [8*8-1:0] what,
			input logic [63:0] exp, input logic [63:0] act);
		checks++;
		assert (exp === act) else begin
			$display("FAILED %0s %0s: expected %0h, got %0h", name, what, exp, act);
			value_errs++;
		end
	endtask

	// setup and access cycle, then one idle cycle
	task automatic apb_xfer(input logic wr, input paddr_t addr, input pdata_t wdata,
			output pdata_t rdata, output logic err);
		int waited;
		@(negedge clk);
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge clk);
		penable = 1'b1;
		#1;
		waited = 0;
		while (!pready && waited < 16) begin
			@(negedge clk);
			#1;
			waited++;
		end
		assert (pready) else begin
			$display("apb transfer to %h never got pready", addr);
			other_errs++;
		end
		rdata = prdata;
		err   = pslverr;
		@(negedge clk);
		psel    = 1'b0;
		penable = 1'b0;
	endtask

	task automatic wait_rx(input int count, input int limit);
		int waited;
		waited = 0;
		while (rx_q.size() < count && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		assert (rx_q.size() >= count) else begin
			$display("uart line delivered %0d of %0d bytes in time", rx_q.size(), count);
			other_errs++;
		end
	endtask

	// ------------------------------
	// uart line monitor

	// every sample of a bit must match the first one
	initial begin : uart_monitor
		logic [9:0] frame;
		logic       stable;
		forever begin
			@(negedge clk);
			if (rst_n && !uart_tx) begin
				stable = 1'b1;
				for (int b = 0; b < 10; b++) begin
					for (int s = 0; s < `UART_CLKDIV; s++) begin
						if (b != 0 || s != 0)
							@(negedge clk);
						if (s == 0)
							frame[b] = uart_tx;
						else if (uart_tx !== frame[b])
							stable = 1'b0;
					end
				end
				assert (stable && !frame[0] && frame[9]) else begin
					$display("uart frame badly timed or framed, bits %b", frame);
					other_errs++;
				end
				rx_q.push_back(frame[8:1]);
			end
		end
	end

	// ------------------------------
	// main sequence

	initial begin : main
		int          fd;
		int          n;
		int          waited;
		logic [8*4-1:0]  op;
		logic [8*32-1:0] name;
		logic [8*128-1:0] line;
		paddr_t      addr;
		pdata_t      wdata;
		logic [31:0] exp_rd;
		logic [31:0] exp_err;
		pdata_t      rd;
		pdata_t      rd2;
		logic        err;
		logic        rejected;
		logic [7:0]  b;

		checks     = 0;
		value_errs = 0;
		other_errs = 0;
		lfsr       = 32'h71d9;
		rst_n      = 1'b0;
		psel       = 1'b0;
		penable    = 1'b0;
		pwrite     = 1'b0;
		paddr      = '0;
		pwdata     = '0;
		dbg_halt   = 1'b0;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_value("reset", "uart_tx", 1, uart_tx);
		check_value("reset", "irq", 0, timer_irq);

		// register read-back and error cases
		fd = $fopen("sim/periph_cases.txt", "r");
		assert (fd != 0) else begin
			$display("case file sim/periph_cases.txt could not be opened");
			other_errs++;
		end
		if (fd != 0) begin
			while ($fscanf(fd, "%s", op) == 1) begin
				if (op == "#") begin
					n = $fgets(line, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h %s", addr, wdata, exp_rd, exp_err, name);
					assert (n == 5) else begin
						$display("case line starting with %0s could not be parsed", op);
						other_errs++;
					end
					if (n == 5) begin
						apb_xfer(op == "W", addr, wdata, rd, err);
						check_value(name, "pslverr", exp_err, err);
						if (op == "R")
							check_value(name, "rdata", exp_rd, rd);
					end
				end
			end
			$fclose(fd);
		end

		// framing of three random bytes
		for (int i = 0; i < 3; i++) begin
			rand_byte(b);
			exp_q.push_back(b);
			apb_xfer(1'b1, uart_base | `UART_TXDATA_OFS, pdata_t'(b), rd, err);
			check_value("tx_write", "pslverr", 0, err);
		end
		wait_rx(3, 4 * frame_cycles);
		while (exp_q.size() > 0 && rx_q.size() > 0)
			check_value("uart_frame", "byte", exp_q.pop_front(), rx_q.pop_front());
		exp_q.delete();
		rx_q.delete();

		// depth plus two writes against a filling fifo
		rejected = 1'b0;
		for (int i = 0; i < `TX_FIFO_DEPTH + 2; i++) begin
			rand_byte(b);
			apb_xfer(1'b1, uart_base | `UART_TXDATA_OFS, pdata_t'(b), rd, err);
			if (err) begin
				rejected = 1'b1;
			end else begin
				assert (!rejected) else begin
					$display("fifo accepted a byte after rejecting an earlier one");
					other_errs++;
				end
				exp_q.push_back(b);
			end
		end
		assert (exp_q.size() == `TX_FIFO_DEPTH || exp_q.size() == `TX_FIFO_DEPTH + 1) else begin
			$display("fifo took %0d bytes, more or fewer than its capacity", exp_q.size());
			other_errs++;
		end
		apb_xfer(1'b0, uart_base | `UART_STATUS_OFS, '0, rd, err);
		check_value("status_full", "full", 1, rd[0]);
		check_value("status_full", "level", `TX_FIFO_DEPTH, rd[3:1]);
		wait_rx(exp_q.size(), (exp_q.size() + 1) * frame_cycles);
		// drain until the serializer goes idle
		waited = 0;
		rd     = '1;
		while (rd[4] && waited < 4 * frame_cycles) begin
			apb_xfer(1'b0, uart_base | `UART_STATUS_OFS, '0, rd, err);
			waited++;
		end
		assert (!rd[4]) else begin
			$display("serializer still busy after the fifo drained");
			other_errs++;
		end
		check_value("bp_count", "bytes", exp_q.size(), rx_q.size());
		while (exp_q.size() > 0 && rx_q.size() > 0)
			check_value("bp_frame", "byte", exp_q.pop_front(), rx_q.pop_front());

		// timer irq with mtime cleared while disabled
		apb_xfer(1'b1, `TMR_MTIME_HI_OFS, '0, rd, err);
		apb_xfer(1'b1, `TMR_MTIME_LO_OFS, '0, rd, err);
		apb_xfer(1'b1, `TMR_CMP_HI_OFS, '0, rd, err);
		apb_xfer(1'b1, `TMR_CMP_LO_OFS, 32'd5, rd, err);
		check_value("irq_armed", "irq", 0, timer_irq);
		apb_xfer(1'b1, `TMR_CTRL_OFS, 32'd1, rd, err);
		waited = 0;
		while (!timer_irq && waited < 5 * `CLK_MHZ + 4) begin
			@(negedge clk);
			waited++;
		end
		assert (timer_irq) else begin
			$display("timer interrupt did not rise in time");
			other_errs++;
		end
		apb_xfer(1'b1, `TMR_CMP_LO_OFS, 32'd1000, rd, err);
		waited = 0;
		while (timer_irq && waited < 4) begin
			@(negedge clk);
			waited++;
		end
		assert (!timer_irq) else begin
			$display("timer interrupt stayed high after a larger compare value");
			other_errs++;
		end

		// debug halt freezes mtime
		@(negedge clk);
		dbg_halt = 1'b1;
		apb_xfer(1'b0, `TMR_MTIME_LO_OFS, '0, rd, err);
		repeat (20) @(negedge clk);
		apb_xfer(1'b0, `TMR_MTIME_LO_OFS, '0, rd2, err);
		check_value("dbg_halt", "mtime", rd, rd2);
		@(negedge clk);
		dbg_halt = 1'b0;
		waited   = 0;
		while (rd2 <= rd && waited < 4 * `CLK_MHZ) begin
			apb_xfer(1'b0, `TMR_MTIME_LO_OFS, '0, rd2, err);
			waited++;
		end
		assert (rd2 > rd) else begin
			$display("mtime did not advance after debug halt was released");
			other_errs++;
		end

		$display("checks %0d, value errors %0d, other errors %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* sim/periph_cases.txt */
# op addr wdata exp_rdata exp_pslverr name
# op W or R, numbers in hex, exp_rdata only checked on reads
W 0010 a5a50f0f 00000000 0 cmp_lo_wr
R 0010 00000000 a5a50f0f 0 cmp_lo_rd
W 0014 12345678 00000000 0 cmp_hi_wr
R 0014 00000000 12345678 0 cmp_hi_rd
W 0000 00000001 00000000 0 ctrl_en_wr
R 0000 00000000 00000001 0 ctrl_en_rd
W 0000 00000000 00000000 0 ctrl_dis_wr
R 0000 00000000 00000000 0 ctrl_dis_rd
R 0004 00000000 00000000 1 tmr_hole_rd
W 0004 0000001f 00000000 1 tmr_hole_wr
R 0018 00000000 00000000 1 tmr_past_end_rd
R 4008 00000000 00000000 1 uart_unmapped_rd
W 400c 00000055 00000000 1 uart_unmapped_wr
W 4004 000000ff 00000000 1 status_wr
R 4004 00000000 00000000 0 status_idle_rd
R 8000 00000000 00000000 1 above_region_rd
W 0010 ffffffff 00000000 0 cmp_lo_restore
W 0014 ffffffff 00000000 0 cmp_hi_restore
R 0014 00000000 ffffffff 0 cmp_hi_restore_rd

/* vlog.f */
+incdir+hdl
hdl/apb_bus_pkg.sv
hdl/periph_pkg.sv
hdl/periph_if.sv
hdl/apb_periph_regs.sv
hdl/mtimer.sv
hdl/tx_fifo.sv
hdl/uart_tx_serial.sv
hdl/periph_top.sv
sim/tb_periph_top.sv
